// ==== src/brisc_isa_pkg.sv ====
package brisc_isa_pkg;

  // Data path and address width
  parameter int XLEN = 32;

  // 8 architectural registers
  parameter int REG_BITS = 3;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLT  = 4'd5,
    SLTU = 4'd6,
    SLL  = 4'd7,
    SRL  = 4'd8,
    SRA  = 4'd9
  } alu_ctrl_e;

  // First ALU operand
  typedef enum logic {
    FROM_RS1 = 1'b0,
    FROM_PC  = 1'b1
  } alu_src1_e;

  // Second ALU operand
  typedef enum logic {
    FROM_RS2 = 1'b0,
    FROM_IMM = 1'b1
  } alu_src2_e;

endpackage

// ==== src/brisc_pipe_pkg.sv ====
package brisc_pipe_pkg;

  // Writeback source, FROM_CACHE marks a load
  typedef enum logic [1:0] {
    FROM_ALU   = 2'd0,
    FROM_CACHE = 2'd1,
    FROM_PC4   = 2'd2
  } result_src_e;

  // Next PC, sequential or redirect from execute
  typedef enum logic {
    FROM_F = 1'b0,
    FROM_E = 1'b1
  } pc_src_e;

  typedef enum logic [1:0] {
    B = 2'd0,
    H = 2'd1,
    W = 2'd2
  } data_size_e;

  typedef enum logic [1:0] {
    NO_XCPT       = 2'd0,
    MEM_UNALIGNED = 2'd1,
    ADDR_INVALID  = 2'd2
  } xcpt_e;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  logic [brisc_isa_pkg::XLEN-1:0] src1,
  input  logic [brisc_isa_pkg::XLEN-1:0] src2,
  input  brisc_isa_pkg::alu_ctrl_e       ctrl,
  output logic [brisc_isa_pkg::XLEN-1:0] result,
  output logic                           zero
);
  import brisc_isa_pkg::*;

  logic [4:0] shamt;

  assign shamt = src2[4:0];

  always_comb begin
    case (ctrl)
      ADD: begin
        result = src1 + src2;
      end
      SUB: begin
        result = src1 - src2;
      end
      AND: begin
        result = src1 & src2;
      end
      OR: begin
        result = src1 | src2;
      end
      XOR: begin
        result = src1 ^ src2;
      end
      SLT: begin
        result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
      end
      SLTU: begin
        result = {{(XLEN-1){1'b0}}, src1 < src2};
      end
      SLL: begin
        result = src1 << shamt;
      end
      SRL: begin
        result = src1 >> shamt;
      end
      SRA: begin
        result = $signed(src1) >>> shamt;
      end
      default: begin
        result = '0;
        // Only ten of the sixteen encodings exist
        assert ($isunknown(ctrl))
          else $error("alu: undefined opcode %0d", ctrl);
      end
    endcase
  end

  // Branches compare with SUB
  assign zero = (result == '0);

endmodule

// ==== src/branch_resolve.sv ====
`timescale 1ns/100ps

module branch_resolve (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           is_branch,
  input  logic                           is_jump,
  input  logic                           zero,
  input  logic                           branch_prediction,
  input  logic [brisc_isa_pkg::XLEN-1:0] pc,
  input  logic [brisc_isa_pkg::XLEN-1:0] imm,
  output brisc_pipe_pkg::pc_src_e        pc_src,
  output logic [brisc_isa_pkg::XLEN-1:0] pc_target,
  output logic                           mispredict
);
  import brisc_pipe_pkg::*;

  logic taken;

  assign taken = (is_branch && zero) || is_jump;
  assign pc_src = taken ? FROM_E : FROM_F;
  assign pc_target = pc + imm;

  always_comb begin
    if (is_branch) begin
      mispredict = taken != branch_prediction;
    end else if (is_jump) begin
      // Jumps are always taken
      mispredict = !branch_prediction;
    end else begin
      mispredict = 1'b0;
    end
  end

  // Decode never marks an instruction as both
  assert property (@(posedge clk) disable iff (rst) !(is_branch && is_jump))
    else $error("branch_resolve: branch and jump set together");

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/100ps

module regfile (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               we,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] raddr1,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] raddr2,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] waddr,
  input  logic [brisc_isa_pkg::XLEN-1:0]     wdata,
  output logic [brisc_isa_pkg::XLEN-1:0]     rdata1,
  output logic [brisc_isa_pkg::XLEN-1:0]     rdata2
);
  import brisc_isa_pkg::*;

  localparam int NUM_REGS = 2 ** REG_BITS;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      // r0 is never written
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// ==== src/alu_stage.sv ====
`timescale 1ns/100ps

module alu_stage #(
  parameter logic [brisc_isa_pkg::XLEN-1:0] DATA_BASE = 32'h0000_1000
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               load,
  input  brisc_isa_pkg::alu_ctrl_e           alu_ctrl_in,
  input  brisc_isa_pkg::alu_src1_e           alu_src1_in,
  input  brisc_isa_pkg::alu_src2_e           alu_src2_in,
  input  logic [brisc_isa_pkg::XLEN-1:0]     rs1_data_in,
  input  logic [brisc_isa_pkg::XLEN-1:0]     rs2_data_in,
  input  logic [brisc_isa_pkg::XLEN-1:0]     imm_in,
  input  logic [brisc_isa_pkg::XLEN-1:0]     pc_in,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] rd_in,
  input  logic                               reg_write_in,
  input  logic                               mem_write_in,
  input  logic                               is_branch_in,
  input  logic                               is_jump_in,
  input  logic                               branch_prediction_in,
  input  brisc_pipe_pkg::result_src_e        result_src_in,
  input  brisc_pipe_pkg::data_size_e         data_size_in,
  output logic [brisc_isa_pkg::XLEN-1:0]     alu_res_out,
  output logic [brisc_isa_pkg::XLEN-1:0]     pc_plus4_out,
  output logic [brisc_isa_pkg::XLEN-1:0]     write_data_out,
  output logic [brisc_isa_pkg::XLEN-1:0]     pc_target_out,
  output brisc_pipe_pkg::pc_src_e            pc_src_out,
  output logic                               mispredict_out,
  output brisc_pipe_pkg::xcpt_e              xcpt_out,
  output logic [brisc_isa_pkg::REG_BITS-1:0] rd_out,
  output logic                               reg_write_out,
  output logic                               mem_write_out,
  output brisc_pipe_pkg::result_src_e        result_src_out
);
  import brisc_isa_pkg::*;
  import brisc_pipe_pkg::*;

  alu_ctrl_e   alu_ctrl_r;
  alu_src1_e   alu_src1_r;
  alu_src2_e   alu_src2_r;
  result_src_e result_src_r;
  data_size_e  data_size_r;
  logic        reg_write_r;
  logic        mem_write_r;
  logic        is_branch_r;
  logic        is_jump_r;
  logic        prediction_r;

  logic [XLEN-1:0]     rs1_data_r;
  logic [XLEN-1:0]     rs2_data_r;
  logic [XLEN-1:0]     imm_r;
  logic [XLEN-1:0]     pc_r;
  logic [REG_BITS-1:0] rd_r;

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic            zero;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_ctrl_r   <= ADD;
      alu_src1_r   <= FROM_RS1;
      alu_src2_r   <= FROM_RS2;
      result_src_r <= FROM_ALU;
      data_size_r  <= W;
      reg_write_r  <= 1'b0;
      mem_write_r  <= 1'b0;
      is_branch_r  <= 1'b0;
      is_jump_r    <= 1'b0;
      prediction_r <= 1'b0;
    end else if (load) begin
      alu_ctrl_r   <= alu_ctrl_in;
      alu_src1_r   <= alu_src1_in;
      alu_src2_r   <= alu_src2_in;
      result_src_r <= result_src_in;
      data_size_r  <= data_size_in;
      reg_write_r  <= reg_write_in;
      mem_write_r  <= mem_write_in;
      is_branch_r  <= is_branch_in;
      is_jump_r    <= is_jump_in;
      prediction_r <= branch_prediction_in;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rs1_data_r <= rs1_data_in;
      rs2_data_r <= rs2_data_in;
      imm_r      <= imm_in;
      pc_r       <= pc_in;
      rd_r       <= rd_in;
    end
  end

  assign src1 = (alu_src1_r == FROM_PC) ? pc_r : rs1_data_r;
  assign src2 = (alu_src2_r == FROM_IMM) ? imm_r : rs2_data_r;

  alu alu_inst (
    .src1   (src1),
    .src2   (src2),
    .ctrl   (alu_ctrl_r),
    .result (alu_res_out),
    .zero   (zero)
  );

  branch_resolve branch_resolve_inst (
    .clk               (clk),
    .rst               (rst),
    .is_branch         (is_branch_r),
    .is_jump           (is_jump_r),
    .zero              (zero),
    .branch_prediction (prediction_r),
    .pc                (pc_r),
    .imm               (imm_r),
    .pc_src            (pc_src_out),
    .pc_target         (pc_target_out),
    .mispredict        (mispredict_out)
  );

  // Address check for loads and stores
  always_comb begin
    xcpt_out = NO_XCPT;
    if (mem_write_r || result_src_r == FROM_CACHE) begin
      if (data_size_r == W && alu_res_out[1:0] != 2'b00) begin
        xcpt_out = MEM_UNALIGNED;
      end else if (alu_res_out < DATA_BASE) begin
        xcpt_out = ADDR_INVALID;
      end
    end
  end

  assign pc_plus4_out   = pc_r + 32'd4;
  assign write_data_out = rs2_data_r;
  assign rd_out         = rd_r;
  assign reg_write_out  = reg_write_r && (xcpt_out == NO_XCPT);
  assign mem_write_out  = mem_write_r;
  assign result_src_out = result_src_r;

  // Outputs are captured the cycle after load, so loads never come back to back
  assert property (@(posedge clk) disable iff (rst) load |=> !load)
    else $error("alu_stage: load on consecutive cycles");

endmodule

// ==== src/exec_top.sv ====
`timescale 1ns/100ps

module exec_top #(
  parameter logic [brisc_isa_pkg::XLEN-1:0] DATA_BASE = 32'h0000_1000
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               req,
  output logic                               ack,
  input  brisc_isa_pkg::alu_ctrl_e           alu_ctrl,
  input  brisc_isa_pkg::alu_src1_e           alu_src1,
  input  brisc_isa_pkg::alu_src2_e           alu_src2,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] rs1,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] rs2,
  input  logic [brisc_isa_pkg::REG_BITS-1:0] rd,
  input  logic [brisc_isa_pkg::XLEN-1:0]     imm,
  input  logic [brisc_isa_pkg::XLEN-1:0]     pc,
  input  logic                               reg_write,
  input  brisc_pipe_pkg::result_src_e        result_src,
  input  logic                               mem_write,
  input  brisc_pipe_pkg::data_size_e         data_size,
  input  logic                               is_branch,
  input  logic                               is_jump,
  input  logic                               branch_prediction,
  output logic [brisc_isa_pkg::XLEN-1:0]     result,
  output logic [brisc_isa_pkg::XLEN-1:0]     pc_target,
  output logic [brisc_isa_pkg::XLEN-1:0]     write_data,
  output brisc_pipe_pkg::pc_src_e            pc_src,
  output logic                               mispredict,
  output logic                               mem_we,
  output brisc_pipe_pkg::xcpt_e              xcpt
);
  import brisc_isa_pkg::*;
  import brisc_pipe_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    DONE
  } exec_state_e;

  exec_state_e state;
  exec_state_e state_next;
  logic        load;
  logic        we;

  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  logic [XLEN-1:0]     wb_data;
  logic [XLEN-1:0]     alu_res;
  logic [XLEN-1:0]     pc_plus4;
  logic [XLEN-1:0]     st_write_data;
  logic [XLEN-1:0]     st_pc_target;
  pc_src_e             st_pc_src;
  logic                st_mispredict;
  xcpt_e               st_xcpt;
  logic [REG_BITS-1:0] st_rd;
  logic                st_reg_write;
  logic                st_mem_write;
  result_src_e         st_result_src;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_next = EXEC;
        end
      end
      EXEC: begin
        state_next = DONE;
      end
      DONE: begin
        // Hold until the requester lets go
        if (!req) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ack is low in IDLE, so req here is a fresh request
  assign load = (state == IDLE) && req;
  assign ack  = (state == DONE);
  assign we   = (state == EXEC) && st_reg_write;

  assign wb_data = (st_result_src == FROM_PC4) ? pc_plus4 : alu_res;

  regfile regfile_inst (
    .clk    (clk),
    .rst    (rst),
    .we     (we),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .waddr  (st_rd),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  alu_stage #(
    .DATA_BASE (DATA_BASE)
  ) alu_stage_inst (
    .clk                  (clk),
    .rst                  (rst),
    .load                 (load),
    .alu_ctrl_in          (alu_ctrl),
    .alu_src1_in          (alu_src1),
    .alu_src2_in          (alu_src2),
    .rs1_data_in          (rs1_data),
    .rs2_data_in          (rs2_data),
    .imm_in               (imm),
    .pc_in                (pc),
    .rd_in                (rd),
    .reg_write_in         (reg_write),
    .mem_write_in         (mem_write),
    .is_branch_in         (is_branch),
    .is_jump_in           (is_jump),
    .branch_prediction_in (branch_prediction),
    .result_src_in        (result_src),
    .data_size_in         (data_size),
    .alu_res_out          (alu_res),
    .pc_plus4_out         (pc_plus4),
    .write_data_out       (st_write_data),
    .pc_target_out        (st_pc_target),
    .pc_src_out           (st_pc_src),
    .mispredict_out       (st_mispredict),
    .xcpt_out             (st_xcpt),
    .rd_out               (st_rd),
    .reg_write_out        (st_reg_write),
    .mem_write_out        (st_mem_write),
    .result_src_out       (st_result_src)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      result     <= '0;
      pc_target  <= '0;
      write_data <= '0;
      pc_src     <= FROM_F;
      mispredict <= 1'b0;
      mem_we     <= 1'b0;
      xcpt       <= NO_XCPT;
    end else if (state == EXEC) begin
      result     <= wb_data;
      pc_target  <= st_pc_target;
      write_data <= st_write_data;
      pc_src     <= st_pc_src;
      mispredict <= st_mispredict;
      mem_we     <= st_mem_write;
      xcpt       <= st_xcpt;
    end
  end

  // Ack only answers a held request
  assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
    else $error("exec_top: ack rose without req");

endmodule

// ==== testbench/tb_exec_top.sv ====
`timescale 1ns/100ps

module tb_exec_top;
  import brisc_isa_pkg::*;
  import brisc_pipe_pkg::*;

  localparam logic [XLEN-1:0] DATA_BASE = 32'h0000_2000;
  localparam int TIMEOUT = 20;

  logic                clk = 1'b0;
  logic                rst;
  logic                req;
  logic                ack;
  alu_ctrl_e           alu_ctrl;
  alu_src1_e           alu_src1;
  alu_src2_e           alu_src2;
  logic [REG_BITS-1:0] rs1;
  logic [REG_BITS-1:0] rs2;
  logic [REG_BITS-1:0] rd;
  logic [XLEN-1:0]     imm;
  logic [XLEN-1:0]     pc;
  logic                reg_write;
  result_src_e         result_src;
  logic                mem_write;
  data_size_e          data_size;
  logic                is_branch;
  logic                is_jump;
  logic                branch_prediction;
  logic [XLEN-1:0]     result;
  logic [XLEN-1:0]     pc_target;
  logic [XLEN-1:0]     write_data;
  pc_src_e             pc_src;
  logic                mispredict;
  logic                mem_we;
  xcpt_e               xcpt;

  logic [31:0]     lfsr = 32'h299bff5c;
  int              mismatches = 0;
  int              failures = 0;
  logic [XLEN-1:0] ref_regs [8];
  logic [XLEN-1:0] exp_result;
  logic [XLEN-1:0] exp_target;
  logic [XLEN-1:0] exp_wdata;
  pc_src_e         exp_pc_src;
  logic            exp_mispredict;
  logic            exp_mem_we;
  xcpt_e           exp_xcpt;

  always #5 clk = ~clk;

  exec_top #(
    .DATA_BASE (DATA_BASE)
  ) exec_top_inst (
    .clk               (clk),
    .rst               (rst),
    .req               (req),
    .ack               (ack),
    .alu_ctrl          (alu_ctrl),
    .alu_src1          (alu_src1),
    .alu_src2          (alu_src2),
    .rs1               (rs1),
    .rs2               (rs2),
    .rd                (rd),
    .imm               (imm),
    .pc                (pc),
    .reg_write         (reg_write),
    .result_src        (result_src),
    .mem_write         (mem_write),
    .data_size         (data_size),
    .is_branch         (is_branch),
    .is_jump           (is_jump),
    .branch_prediction (branch_prediction),
    .result            (result),
    .pc_target         (pc_target),
    .write_data        (write_data),
    .pc_src            (pc_src),
    .mispredict        (mispredict),
    .mem_we            (mem_we),
    .xcpt              (xcpt)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatches++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Outputs against the model while ack is up
  assert property (@(posedge clk) disable iff (rst) ack |-> result == exp_result)
    else report_mismatch("result", result, exp_result);
  assert property (@(posedge clk) disable iff (rst) ack |-> pc_target == exp_target)
    else report_mismatch("pc_target", pc_target, exp_target);
  assert property (@(posedge clk) disable iff (rst) ack |-> write_data == exp_wdata)
    else report_mismatch("write_data", write_data, exp_wdata);
  assert property (@(posedge clk) disable iff (rst) ack |-> pc_src == exp_pc_src)
    else report_mismatch("pc_src", 32'(pc_src), 32'(exp_pc_src));
  assert property (@(posedge clk) disable iff (rst) ack |-> mispredict == exp_mispredict)
    else report_mismatch("mispredict", 32'(mispredict), 32'(exp_mispredict));
  assert property (@(posedge clk) disable iff (rst) ack |-> mem_we == exp_mem_we)
    else report_mismatch("mem_we", 32'(mem_we), 32'(exp_mem_we));
  assert property (@(posedge clk) disable iff (rst) ack |-> xcpt == exp_xcpt)
    else report_mismatch("xcpt", 32'(xcpt), 32'(exp_xcpt));

  // Handshake
  assert property (@(posedge clk) $fell(rst) |-> !ack)
    else report_failure("ack is high right after reset");
  assert property (@(posedge clk) disable iff (rst) $rose(req) |=> !ack ##1 ack)
    else report_failure("ack did not rise two cycles after req");
  assert property (@(posedge clk) disable iff (rst)
    ack && req |=> ack && $stable(result) && $stable(pc_target) && $stable(xcpt))
    else report_failure("ack or outputs changed while req was held");
  assert property (@(posedge clk) disable iff (rst) ack && !req |=> !ack)
    else report_failure("ack stayed high after req fell");
  assert property (@(posedge clk) disable iff (rst) ack |-> !exec_top_inst.we)
    else report_failure("register write while ack was high");

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [REG_BITS-1:0] rand_reg();
    return REG_BITS'(rand_bits(REG_BITS));
  endfunction

  task automatic stop_on_timeout(input string what);
    failures++;
    $display("Timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (ack !== level && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== level) begin
      stop_on_timeout(level ? "ack never rose" : "ack never fell");
    end
  endtask

  task automatic run_op(input alu_ctrl_e op, input alu_src1_e s1, input alu_src2_e s2,
                        input logic [REG_BITS-1:0] a, input logic [REG_BITS-1:0] b,
                        input logic [REG_BITS-1:0] d, input logic [XLEN-1:0] imm_v,
                        input logic [XLEN-1:0] pc_v, input logic wr,
                        input result_src_e rsrc, input logic mw, input data_size_e sz,
                        input logic br, input logic jp, input logic pred, input int hold);
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    logic [XLEN-1:0] res;
    logic            taken;
    x = (s1 == FROM_PC) ? pc_v : ref_regs[a];
    y = (s2 == FROM_IMM) ? imm_v : ref_regs[b];
    case (op)
      ADD:  res = x + y;
      SUB:  res = x - y;
      AND:  res = x & y;
      OR:   res = x | y;
      XOR:  res = x ^ y;
      SLT:  res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      SLTU: res = (x < y) ? 32'd1 : 32'd0;
      SLL:  res = x << y[4:0];
      SRL:  res = x >> y[4:0];
      SRA:  res = $signed(x) >>> y[4:0];
      default: res = '0;
    endcase
    taken = (br && res == '0) || jp;
    exp_pc_src = taken ? FROM_E : FROM_F;
    exp_target = pc_v + imm_v;
    exp_mispredict = (br || jp) && (taken != pred);
    exp_mem_we = mw;
    exp_xcpt = NO_XCPT;
    if (mw || rsrc == FROM_CACHE) begin
      if (sz == W && res[1:0] != 2'b00) begin
        exp_xcpt = MEM_UNALIGNED;
      end else if (res < DATA_BASE) begin
        exp_xcpt = ADDR_INVALID;
      end
    end
    exp_wdata = ref_regs[b];
    exp_result = (rsrc == FROM_PC4) ? pc_v + 32'd4 : res;
    @(posedge clk);
    alu_ctrl <= op;
    alu_src1 <= s1;
    alu_src2 <= s2;
    rs1 <= a;
    rs2 <= b;
    rd <= d;
    imm <= imm_v;
    pc <= pc_v;
    reg_write <= wr;
    result_src <= rsrc;
    mem_write <= mw;
    data_size <= sz;
    is_branch <= br;
    is_jump <= jp;
    branch_prediction <= pred;
    req <= 1'b1;
    wait_ack(1'b1);
    // Back-pressure
    repeat (hold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0);
    if (wr && exp_xcpt == NO_XCPT && d != '0) begin
      ref_regs[d] = exp_result;
    end
  endtask

  task automatic alu_op(input alu_ctrl_e op, input alu_src1_e s1, input alu_src2_e s2,
                        input logic [REG_BITS-1:0] a, input logic [REG_BITS-1:0] b,
                        input logic [REG_BITS-1:0] d, input logic [XLEN-1:0] imm_v,
                        input logic [XLEN-1:0] pc_v, input int hold);
    run_op(op, s1, s2, a, b, d, imm_v, pc_v, 1'b1, FROM_ALU, 1'b0, W,
           1'b0, 1'b0, 1'b0, hold);
  endtask

  // Address is r0 + imm, then rd is read back through rs1
  task automatic mem_op(input logic [XLEN-1:0] addr, input logic mw, input data_size_e sz,
                        input logic [REG_BITS-1:0] d);
    run_op(ADD, FROM_RS1, FROM_IMM, 3'd0, rand_reg(), d, addr, rand_bits(32), !mw,
           mw ? FROM_ALU : FROM_CACHE, mw, sz, 1'b0, 1'b0, 1'b0, 0);
    alu_op(ADD, FROM_RS1, FROM_RS2, d, 3'd0, 3'd0, 32'd0, 32'd0, 0);
  endtask

  initial begin
    logic [REG_BITS-1:0] a;
    logic [REG_BITS-1:0] b;
    rst = 1'b1;
    req = 1'b0;
    alu_ctrl = ADD;
    alu_src1 = FROM_RS1;
    alu_src2 = FROM_RS2;
    rs1 = '0;
    rs2 = '0;
    rd = '0;
    imm = '0;
    pc = '0;
    reg_write = 1'b0;
    result_src = FROM_ALU;
    mem_write = 1'b0;
    data_size = W;
    is_branch = 1'b0;
    is_jump = 1'b0;
    branch_prediction = 1'b0;
    for (int i = 0; i < 8; i++) begin
      ref_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Seed r1 to r7 through the immediate path
    for (int i = 1; i < 8; i++) begin
      alu_op(ADD, FROM_RS1, FROM_IMM, 3'd0, 3'd0, REG_BITS'(i), rand_bits(32),
             rand_bits(32), 0);
    end
    // Every opcode on random registers with r0 now and then as destination
    for (int i = 0; i < 60; i++) begin
      alu_op(alu_ctrl_e'(4'(i % 10)), FROM_RS1, alu_src2_e'(1'(rand_bits(1))),
             rand_reg(), rand_reg(), rand_reg(), rand_bits(32), rand_bits(32),
             int'(rand_bits(2)));
    end

    alu_op(ADD, FROM_PC, FROM_IMM, rand_reg(), rand_reg(), 3'd5, rand_bits(32),
           rand_bits(32), 0);
    alu_op(SUB, FROM_PC, FROM_RS2, rand_reg(), rand_reg(), 3'd4, rand_bits(32),
           rand_bits(32), 1);
    // Jumps link pc + 4, then r6 is read back
    for (int i = 0; i < 2; i++) begin
      run_op(ADD, FROM_PC, FROM_IMM, 3'd0, 3'd0, 3'd6, rand_bits(32), rand_bits(32), 1'b1,
             FROM_PC4, 1'b0, W, 1'b0, 1'b1, 1'(i), 0);
      alu_op(OR, FROM_RS1, FROM_RS2, 3'd6, 3'd0, 3'd7, 32'd0, 32'd0, 0);
    end

    // Even passes compare a register with itself
    for (int i = 0; i < 8; i++) begin
      a = rand_reg();
      b = (i % 2 == 0) ? a : a + 3'd1;
      run_op(SUB, FROM_RS1, FROM_RS2, a, b, rand_reg(), rand_bits(32), rand_bits(32),
             1'b0, FROM_ALU, 1'b0, W, 1'b1, 1'b0, 1'((i / 2) % 2), 0);
    end

    mem_op(DATA_BASE + 32'd2, 1'b1, W, 3'd0);
    mem_op(32'h0000_0100, 1'b1, W, 3'd0);
    mem_op(DATA_BASE + 32'h40, 1'b1, W, 3'd0);
    mem_op(DATA_BASE + 32'h43, 1'b1, B, 3'd0);
    mem_op(DATA_BASE + 32'h11, 1'b0, W, 3'd3);
    mem_op(32'h0000_0010, 1'b0, H, 3'd4);
    mem_op(DATA_BASE + 32'h80, 1'b0, W, 3'd5);

    repeat (2) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
src/brisc_isa_pkg.sv
src/brisc_pipe_pkg.sv
src/alu.sv
src/branch_resolve.sv
src/regfile.sv
src/alu_stage.sv
src/exec_top.sv
testbench/tb_exec_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_exec_top -f sources.f -o sim_exec
	./obj_dir/sim_exec | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
